// File: cpu16_top.f
+incdir+rtl
+incdir+tb
rtl/cpu16_pkg.sv
rtl/cpu16_mem.sv
rtl/cpu16_alu.sv
rtl/cpu16_regfile.sv
rtl/cpu16_pc_sp.sv
rtl/cpu16_control.sv
rtl/cpu16_top.sv
tb/cpu16_tb.sv

// File: Bender.yml
package:
  name: cpu16

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cpu16_pkg.sv
      - rtl/cpu16_mem.sv
      - rtl/cpu16_alu.sv
      - rtl/cpu16_regfile.sv
      - rtl/cpu16_pc_sp.sv
      - rtl/cpu16_control.sv
      - rtl/cpu16_top.sv
  - target: test
    include_dirs:
      - rtl
      - tb
    files:
      - tb/cpu16_tb.sv

// File: tb/cpu16_tb_programs.svh
`ifndef CPU16_TB_PROGRAMS_SVH
`define CPU16_TB_PROGRAMS_SVH

   localparam int NUM_TESTS  = 8;
   localparam int PROG_LEN   = 16;
   localparam int NUM_CHECKS = 4;

   string                   test_name [NUM_TESTS];
   logic [`CPU_WORD_W-1:0]  prog      [NUM_TESTS][PROG_LEN];   // word 0 at byte address 0
   int                      chk_idx   [NUM_TESTS][NUM_CHECKS];
   logic [`CPU_WORD_W-1:0]  chk_val   [NUM_TESTS][NUM_CHECKS];
   logic [`CPU_FLAGS_W-1:0] chk_flags [NUM_TESTS];             // {ovf, sign, carry, zero}

   // words past the end of a program are HALT
   task automatic fill_table();
      test_name[0] = "ldl_ldh_add";
      prog[0]      = '{0: 16'h11FF, 1: 16'h21FF, 2: 16'h1201, 3: 16'h8312,
                       default: 16'h0001};
      chk_idx[0]   = '{1, 2, 3, 0};
      chk_val[0]   = '{16'hFFFF, 16'h0001, 16'h0000, 16'h0000};
      chk_flags[0] = 4'h3;                                      // zero and carry
      test_name[1] = "sub_overflow";
      prog[1]      = '{0: 16'h2180, 1: 16'h1201, 2: 16'h9312, default: 16'h0001};
      chk_idx[1]   = '{1, 2, 3, 0};
      chk_val[1]   = '{16'h8000, 16'h0001, 16'h7FFF, 16'h0000};
      chk_flags[1] = 4'h8;
      test_name[2] = "cp_equal";
      prog[2]      = '{0: 16'h1134, 1: 16'h2112, 2: 16'h1234, 3: 16'h2212,
                       4: 16'h1355, 5: 16'hF312, default: 16'h0001};
      chk_idx[2]   = '{1, 2, 3, 0};
      chk_val[2]   = '{16'h1234, 16'h1234, 16'h0055, 16'h0000};  // r3 untouched by CP
      chk_flags[2] = 4'h1;
      test_name[3] = "xor_parity";
      prog[3]      = '{0: 16'h110F, 1: 16'h21F0, 2: 16'h12FF, 3: 16'h8411,
                       4: 16'hE312, default: 16'h0001};
      chk_idx[3]   = '{1, 2, 3, 4};
      chk_val[3]   = '{16'hF00F, 16'h00FF, 16'hF0F0, 16'hE01E};
      chk_flags[3] = 4'hC;                                      // carry from ADD cleared
      test_name[4] = "store_load";
      prog[4]      = '{0: 16'h2104, 1: 16'h12CD, 2: 16'h22AB, 3: 16'h3221,
                       4: 16'h3051, default: 16'h0001};
      chk_idx[4]   = '{1, 2, 5, 0};
      chk_val[4]   = '{16'h0400, 16'hABCD, 16'hABCD, 16'h0000};
      chk_flags[4] = 4'h0;
      test_name[5] = "push_pop";
      prog[5]      = '{0: 16'h1111, 1: 16'h1222, 2: 16'h0101, 3: 16'h0102,
                       4: 16'h0113, 5: 16'h0114, default: 16'h0001};
      chk_idx[5]   = '{1, 2, 3, 4};
      chk_val[5]   = '{16'h0011, 16'h0022, 16'h0022, 16'h0011};
      chk_flags[5] = 4'h0;
      test_name[6] = "loop_jump";
      prog[6]      = '{0: 16'h1105, 1: 16'h1201, 2: 16'h1306, 3: 16'h9112,
                       4: 16'h0303, 5: 16'h1410, 6: 16'h01E4, 7: 16'h15BB,
                       8: 16'h0001, default: 16'h0001};
      chk_idx[6]   = '{1, 3, 4, 5};
      chk_val[6]   = '{16'h0000, 16'h0006, 16'h0010, 16'h0000};  // r5 load skipped
      chk_flags[6] = 4'h1;
      test_name[7] = "unused_halt";
      prog[7]      = '{0: 16'h1177, 1: 16'h1212, 2: 16'h1303, 3: 16'hA123,
                       default: 16'h0001};
      chk_idx[7]   = '{1, 2, 3, 0};
      chk_val[7]   = '{16'h0077, 16'h0012, 16'h0003, 16'h0000};
      chk_flags[7] = 4'h0;
   endtask

`endif

// File: tb/cpu16_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu16_defines.svh"

module cpu16_tb;

   localparam int HALT_TIMEOUT = 2000;
   localparam int RESET_CYCLES = 16;
   localparam int HOLD_CYCLES  = 50;

   logic                    clk;
   logic                    reset;
   logic                    load_we;
   logic [`CPU_MEM_AW-1:0]  load_addr;
   logic [`CPU_WORD_W-1:0]  load_data;
   logic [`CPU_REG_AW-1:0]  dbg_sel;
   logic [`CPU_WORD_W-1:0]  dbg_data;
   logic [`CPU_FLAGS_W-1:0] flags;
   logic                    halted;

   int pass_count;
   int fail_count;
   int errors;          // failed checks in the current test

   `include "cpu16_tb_programs.svh"

   cpu16_top DUT (
      .clk, .reset, .load_we, .load_addr, .load_data,
      .dbg_sel, .dbg_data, .flags, .halted
   );

   always #20 clk = ~clk;

   // reset held while the program goes in one word per cycle
   task automatic load_program(input int t);
      for (int i = 0; i < RESET_CYCLES; i++) begin
         @(posedge clk);
         reset     <= 1'b1;
         load_we   <= 1'b1;
         load_addr <= i[`CPU_MEM_AW-1:0];
         load_data <= prog[t][i];
      end
      @(posedge clk);
      reset   <= 1'b0;
      load_we <= 1'b0;
   endtask

   task automatic wait_for_halt(output bit seen);
      int cycles;
      seen   = 1'b0;
      cycles = 0;
      while (!seen && cycles < HALT_TIMEOUT) begin
         @(negedge clk);
         seen = halted;
         cycles++;
      end
   endtask

   task automatic read_reg(input int idx, output logic [`CPU_WORD_W-1:0] value);
      @(posedge clk);
      dbg_sel <= idx[`CPU_REG_AW-1:0];
      @(negedge clk);                  // dbg_data settled
      value = dbg_data;
   endtask

   task automatic run_test(input int t);
      logic [`CPU_WORD_W-1:0] snap [`CPU_NUM_REGS];
      logic [`CPU_WORD_W-1:0] value;
      bit                     seen;
      bit                     held;
      errors = 0;
      load_program(t);
      wait_for_halt(seen);
      if (!seen) begin
         $display("test %0d %s: halted never rose", t, test_name[t]);
         errors++;
      end else begin
         for (int r = 0; r < `CPU_NUM_REGS; r++) begin
            read_reg(r, snap[r]);
         end
         held = 1'b1;
         repeat (HOLD_CYCLES) begin
            @(negedge clk);
            if (!halted)
               held = 1'b0;
         end
         if (!held) begin
            $display("halted fell while the CPU should stay halted");
            errors++;
         end
         for (int r = 0; r < `CPU_NUM_REGS; r++) begin
            read_reg(r, value);
            if (value !== snap[r]) begin
               $display("MISMATCH r%0d after halt: dbg_data=0x%04h expected 0x%04h",
                        r, value, snap[r]);
               errors++;
            end
         end
         for (int k = 0; k < NUM_CHECKS; k++) begin
            if (snap[chk_idx[t][k]] !== chk_val[t][k]) begin
               $display("MISMATCH r%0d: dbg_data=0x%04h expected 0x%04h",
                        chk_idx[t][k], snap[chk_idx[t][k]], chk_val[t][k]);
               errors++;
            end
         end
         if (flags !== chk_flags[t]) begin
            $display("MISMATCH flags: 0x%01h expected 0x%01h", flags, chk_flags[t]);
            errors++;
         end
      end
      $display("test %0d %s: %s", t, test_name[t], (errors == 0) ? "passed" : "failed");
      if (errors == 0)
         pass_count++;
      else
         fail_count++;
   endtask

   initial begin
      clk        = 1'b0;
      reset      = 1'b1;
      load_we    = 1'b0;
      load_addr  = '0;
      load_data  = '0;
      dbg_sel    = '0;
      pass_count = 0;
      fail_count = 0;
      fill_table();
      for (int t = 0; t < NUM_TESTS; t++) begin
         run_test(t);
      end
      $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: rtl/cpu16_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu16_defines.svh"

module cpu16_top import cpu16_pkg::*; (
   input  wire logic                   clk,
   input  wire logic                   reset,
   input  wire logic                   load_we,
   input  wire logic [`CPU_MEM_AW-1:0] load_addr,
   input  wire word_t                  load_data,
   input  wire reg_idx_t               dbg_sel,
   output word_t                       dbg_data,
   output logic [`CPU_FLAGS_W-1:0]     flags,
   output logic                        halted
);

   word_t    mem_rdata;
   word_t    mem_addr;
   word_t    mem_wdata;
   logic     mem_req;
   logic     mem_we;
   word_t    pc;
   word_t    sp;
   word_t    pc_target;
   logic     pc_inc;
   logic     pc_load;
   logic     sp_push;
   logic     sp_pop;
   reg_idx_t sel_a;
   reg_idx_t sel_b;
   reg_idx_t reg_wsel;
   word_t    rd_a;
   word_t    rd_b;
   word_t    reg_wdata;
   logic     reg_we;
   logic     alu_en;
   alu_op_t  alu_op;
   word_t    alu_result;

   cpu16_control u_control (
      .clk, .reset, .mem_rdata, .flags, .pc, .sp, .rd_a, .rd_b, .alu_result,
      .mem_req, .mem_we, .mem_addr, .mem_wdata,
      .pc_inc, .pc_load, .pc_target, .sp_push, .sp_pop,
      .sel_a, .sel_b, .reg_we, .reg_wsel, .reg_wdata,
      .alu_en, .alu_op, .halted
   );

   cpu16_pc_sp u_pc_sp (
      .clk, .reset, .pc_inc, .pc_load, .pc_target, .sp_push, .sp_pop, .pc, .sp
   );

   cpu16_regfile u_regfile (
      .clk, .reset, .sel_a, .sel_b, .dbg_sel,
      .reg_we, .reg_wsel, .reg_wdata, .rd_a, .rd_b, .dbg_data
   );

   cpu16_alu u_alu (
      .clk, .reset, .alu_en, .alu_op, .a(rd_a), .b(rd_b),
      .result(alu_result), .flags
   );

   cpu16_mem u_mem (
      .clk, .mem_req, .mem_we, .mem_addr, .mem_wdata,
      .load_we, .load_addr, .load_data, .mem_rdata
   );

endmodule

`default_nettype wire

// File: rtl/cpu16_control.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu16_defines.svh"

module cpu16_control import cpu16_pkg::*; (
   input  wire logic                    clk,
   input  wire logic                    reset,
   input  wire word_t                   mem_rdata,
   input  wire logic [`CPU_FLAGS_W-1:0] flags,
   input  wire word_t                   pc,
   input  wire word_t                   sp,
   input  wire word_t                   rd_a,
   input  wire word_t                   rd_b,
   input  wire word_t                   alu_result,
   output logic                         mem_req,
   output logic                         mem_we,
   output word_t                        mem_addr,
   output word_t                        mem_wdata,
   output logic                         pc_inc,
   output logic                         pc_load,
   output word_t                        pc_target,
   output logic                         sp_push,
   output logic                         sp_pop,
   output reg_idx_t                     sel_a,
   output reg_idx_t                     sel_b,
   output logic                         reg_we,
   output reg_idx_t                     reg_wsel,
   output word_t                        reg_wdata,
   output logic                         alu_en,
   output alu_op_t                      alu_op,
   output logic                         halted
);

   cpu_state_t state;
   cpu_state_t state_next;
   cpu_op_t    op;
   word_t      ins;
   word_t      reg_wdata_ctl;
   reg_idx_t   load_dst;          // target of a pending LOAD or POP
   logic       load_pend;
   logic       cond_true;

   assign ins       = mem_rdata;  // valid in S_EXEC only
   assign halted    = (state == S_HALT);
   assign cond_true = (flags[ins[5:4]] == ins[6]);
   assign sel_b     = ins[3:0];
   assign sel_a     = (op == OP_LDL || op == OP_LDH) ? ins[11:8] : ins[7:4];
   assign reg_wdata = alu_en ? alu_result : reg_wdata_ctl;

   // instruction decode
   always_comb begin
      op     = OP_NOP;
      alu_op = ALU_ADD;
      case (ins[15:12])
         4'h0: begin
            if (ins == `CPU_INS_HALT)
               op = OP_HALT;
            else if (ins[15:4] == `CPU_OPC_PUSH)
               op = OP_PUSH;
            else if (ins[15:4] == `CPU_OPC_POP)
               op = OP_POP;
            else if (ins[15:4] == `CPU_OPC_JP)
               op = OP_JP;
            else if (ins[15:8] == `CPU_OPC_JCOND && !ins[7])
               op = ins[6] ? OP_JPF : OP_JPN;  // relative forms fall to NOP
         end
         `CPU_OPC_LDL: op = OP_LDL;
         `CPU_OPC_LDH: op = OP_LDH;
         4'h3: begin
            if (ins[15:8] == `CPU_OPC_LOAD)
               op = OP_LOAD;
            else if (ins[15:8] == `CPU_OPC_STORE)
               op = OP_STORE;
         end
         4'h8: begin op = OP_ALU; alu_op = ALU_ADD; end
         4'h9: begin op = OP_ALU; alu_op = ALU_SUB; end
         4'hC: begin op = OP_ALU; alu_op = ALU_AND; end
         4'hD: begin op = OP_ALU; alu_op = ALU_OR;  end
         4'hE: begin op = OP_ALU; alu_op = ALU_XOR; end
         4'hF: begin op = OP_ALU; alu_op = ALU_CP;  end
         default: op = OP_NOP;                    // MUL, DIV and the rest
      endcase
   end

   // strobes and next state
   always_comb begin
      state_next    = state;
      mem_req       = 1'b0;
      mem_we        = 1'b0;
      mem_addr      = pc;
      mem_wdata     = rd_a;
      pc_inc        = 1'b0;
      pc_load       = 1'b0;
      pc_target     = rd_b;
      sp_push       = 1'b0;
      sp_pop        = 1'b0;
      reg_we        = 1'b0;
      reg_wsel      = ins[11:8];
      reg_wdata_ctl = mem_rdata;
      alu_en        = 1'b0;
      case (state)
         S_FETCH: begin
            mem_req    = 1'b1;                   // instruction read at pc
            state_next = S_EXEC;
         end
         S_EXEC: begin
            pc_inc     = 1'b1;
            state_next = S_FETCH;
            case (op)
               OP_HALT: begin
                  pc_inc     = 1'b0;             // pc stays on the HALT
                  state_next = S_HALT;
               end
               OP_PUSH: begin
                  mem_req    = 1'b1;
                  mem_we     = 1'b1;
                  mem_addr   = sp - word_t'(2);  // pre-decrement
                  mem_wdata  = rd_b;
                  sp_push    = 1'b1;
                  state_next = S_MEM;
               end
               OP_POP: begin
                  mem_req    = 1'b1;
                  mem_addr   = sp;
                  sp_pop     = 1'b1;
                  state_next = S_MEM;
               end
               OP_JP: pc_load = 1'b1;
               OP_JPF, OP_JPN: pc_load = cond_true;
               OP_LDL: begin
                  reg_we        = 1'b1;
                  reg_wdata_ctl = {rd_a[15:8], ins[7:0]};
               end
               OP_LDH: begin
                  reg_we        = 1'b1;
                  reg_wdata_ctl = {ins[7:0], rd_a[7:0]};
               end
               OP_LOAD, OP_STORE: begin
                  mem_req    = 1'b1;
                  mem_we     = (op == OP_STORE);
                  mem_addr   = rd_b;             // address in rb
                  state_next = S_MEM;
               end
               OP_ALU: begin
                  alu_en = 1'b1;
                  reg_we = (alu_op != ALU_CP);   // CP only touches flags
               end
               default: ;
            endcase
         end
         S_MEM: begin
            reg_we     = load_pend;              // read data arrives now
            reg_wsel   = load_dst;
            state_next = S_FETCH;
         end
         default: state_next = S_HALT;           // left by reset only
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= S_FETCH;
         load_pend <= 1'b0;
      end else begin
         state <= state_next;
         if (state == S_EXEC)
            load_pend <= (op == OP_LOAD || op == OP_POP);
      end
   end

   always_ff @(posedge clk) begin
      if (state == S_EXEC)
         load_dst <= (op == OP_POP) ? ins[3:0] : ins[7:4];
   end

endmodule

`default_nettype wire

// File: rtl/cpu16_pc_sp.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu16_defines.svh"

module cpu16_pc_sp import cpu16_pkg::*; (
   input  wire logic  clk,
   input  wire logic  reset,
   input  wire logic  pc_inc,
   input  wire logic  pc_load,
   input  wire word_t pc_target,
   input  wire logic  sp_push,
   input  wire logic  sp_pop,
   output word_t      pc,
   output word_t      sp
);

   localparam word_t SP_STEP = word_t'(2);   // one word in bytes

   // a taken jump wins over the increment
   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
      end else if (pc_load) begin
         pc <= pc_target;
      end else if (pc_inc) begin
         pc <= pc + word_t'(`CPU_PC_STEP);
      end
   end

   // stack pointer
   always_ff @(posedge clk) begin
      if (reset) begin
         sp <= word_t'(`CPU_SP_RESET);
      end else if (sp_push) begin
         sp <= sp - SP_STEP;
      end else if (sp_pop) begin
         sp <= sp + SP_STEP;
      end
   end

endmodule

`default_nettype wire

// File: rtl/cpu16_regfile.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu16_defines.svh"

module cpu16_regfile import cpu16_pkg::*; (
   input  wire logic     clk,
   input  wire logic     reset,
   input  wire reg_idx_t sel_a,
   input  wire reg_idx_t sel_b,
   input  wire reg_idx_t dbg_sel,
   input  wire logic     reg_we,
   input  wire reg_idx_t reg_wsel,
   input  wire word_t    reg_wdata,
   output word_t         rd_a,
   output word_t         rd_b,
   output word_t         dbg_data
);

   word_t regs [`CPU_NUM_REGS];

   assign rd_a     = regs[sel_a];
   assign rd_b     = regs[sel_b];
   assign dbg_data = regs[dbg_sel];   // observation only

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `CPU_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (reg_we) begin
         regs[reg_wsel] <= reg_wdata;
      end
   end

endmodule

`default_nettype wire

// File: rtl/cpu16_alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu16_defines.svh"

module cpu16_alu import cpu16_pkg::*; (
   input  wire logic             clk,
   input  wire logic             reset,
   input  wire logic             alu_en,
   input  wire alu_op_t          alu_op,
   input  wire word_t            a,
   input  wire word_t            b,
   output word_t                 result,
   output logic [`CPU_FLAGS_W-1:0] flags
);

   localparam int MSB = `CPU_WORD_W - 1;

   logic [`CPU_WORD_W:0]    a_x;
   logic [`CPU_WORD_W:0]    b_x;
   logic [`CPU_WORD_W:0]    res_x;       // bit 16 is carry or borrow
   logic [`CPU_FLAGS_W-1:0] flags_next;
   logic                    arith;

   always_comb begin
      a_x   = {1'b0, a};
      b_x   = {1'b0, b};
      arith = 1'b1;
      case (alu_op)
         ALU_ADD:         res_x = a_x + b_x;
         ALU_SUB, ALU_CP: res_x = a_x - b_x;
         ALU_AND: begin
            res_x = a_x & b_x;
            arith = 1'b0;
         end
         ALU_OR: begin
            res_x = a_x | b_x;
            arith = 1'b0;
         end
         ALU_XOR: begin
            res_x = a_x ^ b_x;
            arith = 1'b0;
         end
         default: res_x = a_x + b_x;
      endcase
   end

   assign result = res_x[MSB:0];

   always_comb begin
      flags_next[`CPU_FLAG_ZERO]  = (result == '0);
      flags_next[`CPU_FLAG_SIGN]  = res_x[MSB];
      flags_next[`CPU_FLAG_CARRY] = arith & res_x[`CPU_WORD_W];
      if (!arith)
         flags_next[`CPU_FLAG_OVF] = ~^result;   // even parity for logic ops
      else if (alu_op == ALU_ADD)
         flags_next[`CPU_FLAG_OVF] = (a[MSB] == b[MSB]) && (result[MSB] != a[MSB]);
      else
         flags_next[`CPU_FLAG_OVF] = (a[MSB] != b[MSB]) && (result[MSB] != a[MSB]);
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         flags <= '0;
      end else if (alu_en) begin
         flags <= flags_next;
      end
   end

endmodule

`default_nettype wire

// File: rtl/cpu16_mem.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu16_defines.svh"

module cpu16_mem (
   input  wire logic                   clk,
   input  wire logic                   mem_req,
   input  wire logic                   mem_we,
   input  wire logic [`CPU_WORD_W-1:0] mem_addr,
   input  wire logic [`CPU_WORD_W-1:0] mem_wdata,
   input  wire logic                   load_we,
   input  wire logic [`CPU_MEM_AW-1:0] load_addr,
   input  wire logic [`CPU_WORD_W-1:0] load_data,
   output logic [`CPU_WORD_W-1:0]      mem_rdata
);

   logic [`CPU_WORD_W-1:0] mem [2**`CPU_MEM_AW];
   logic [`CPU_MEM_AW-1:0] word_addr;

   // word index with byte address bit 0 dropped
   assign word_addr = mem_addr[`CPU_MEM_AW:1];

   // preload runs only under reset
   always_ff @(posedge clk) begin
      if (load_we) begin
         mem[load_addr] <= load_data;
      end else if (mem_req && mem_we) begin
         mem[word_addr] <= mem_wdata;
      end
   end

   // read data held until the next read
   always_ff @(posedge clk) begin
      if (mem_req && !mem_we) begin
         mem_rdata <= mem[word_addr];
      end
   end

endmodule

`default_nettype wire

// File: rtl/cpu16_pkg.sv
`default_nettype none

`include "cpu16_defines.svh"

package cpu16_pkg;

   typedef logic [`CPU_WORD_W-1:0] word_t;   // data word and byte address
   typedef logic [`CPU_REG_AW-1:0] reg_idx_t;

   typedef enum logic [1:0] {
      S_FETCH,
      S_EXEC,
      S_MEM,     // second half of a data access
      S_HALT
   } cpu_state_t;

   typedef enum logic [3:0] {
      OP_NOP,
      OP_HALT,
      OP_PUSH,
      OP_POP,
      OP_JP,
      OP_JPF,    // jump if flag set
      OP_JPN,    // jump if flag clear
      OP_LDL,
      OP_LDH,
      OP_LOAD,
      OP_STORE,
      OP_ALU
   } cpu_op_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_CP     // subtract for flags only
   } alu_op_t;

endpackage

`default_nettype wire

// File: rtl/cpu16_defines.svh
`ifndef CPU16_DEFINES_SVH
`define CPU16_DEFINES_SVH

`define CPU_WORD_W      16
`define CPU_REG_AW      4
`define CPU_NUM_REGS    16
`define CPU_MEM_AW      12           // 4096 words
`define CPU_PC_STEP     2            // bytes per instruction
`define CPU_SP_RESET    16'h2000     // byte address, grows down
`define CPU_FLAGS_W     4

`define CPU_FLAG_ZERO   0
`define CPU_FLAG_CARRY  1
`define CPU_FLAG_SIGN   2
`define CPU_FLAG_OVF    3

// instruction field values
`define CPU_INS_HALT    16'h0001
`define CPU_OPC_PUSH    12'h010      // ins[15:4]
`define CPU_OPC_POP     12'h011      // ins[15:4]
`define CPU_OPC_JP      12'h01E      // ins[15:4]
`define CPU_OPC_JCOND   8'h03        // ins[15:8], sense in ins[6]
`define CPU_OPC_LDL     4'h1         // ins[15:12]
`define CPU_OPC_LDH     4'h2
`define CPU_OPC_LOAD    8'h30        // ins[15:8]
`define CPU_OPC_STORE   8'h32

`endif
